// ==== build.f ====
+incdir+src
+incdir+test
src/bus_pkg.sv
src/cache_pkg.sv
src/dcache_mem.sv
src/dcache_ctrl.sv
src/dcache.sv
test/tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the cache and its testbench with Verilator, run, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dcache -f build.f -Mdir obj_dir \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_dcache > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "^Everything OK$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== test/tb_dcache_tasks.svh ====
`ifndef TB_DCACHE_TASKS_SVH
`define TB_DCACHE_TASKS_SVH

// line written by the store miss test and evicted later
localparam logic [63:0] STORE_ADDR = 64'h2010;
localparam logic [63:0] STORE_WORD = 64'hdead_beef_0123_4567;
localparam logic [63:0] SNOOP_ADDR = 64'h4018;

// ****************************************
// checks and reporting
// ****************************************

task automatic check_word(input string what, input logic [63:0] got, input logic [63:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		errors++;
	end
endtask

task automatic check_cond(input string what, input logic ok);
	checks++;
	assert (ok) else begin
		$display("%s", what);
		errors++;
	end
endtask

task automatic check_bus(input int pos, input bus_msg_t msg, input logic [63:0] addr);
	if (pos >= log_msg.size()) begin
		check_cond($sformatf("bus request %s to %h never appeared", msg.name(), addr), 1'b0);
	end else begin
		check_word("bus request message", log_msg[pos], msg);
		check_word("bus request address", log_addr[pos], addr);
	end
endtask

task automatic check_traffic(input int start, input int n, input string what);
	check_cond($sformatf("%s: expected %0d bus requests but saw %0d", what, n,
		log_msg.size() - start), (log_msg.size() - start) == n);
endtask

task automatic report_test(input string name, input int err_before);
	tests++;
	$display("test %0d, %s: finished with %0d errors", tests, name, errors - err_before);
endtask

function automatic logic [63:0] line_addr(input logic [63:0] a);
	return a & ~64'h7;
endfunction

// ****************************************
// drivers
// ****************************************

task automatic core_access(input logic we, input logic [63:0] addr, input logic [63:0] wdata,
	output logic [63:0] rdata);
	logic accepted;
	req_valid_i = 1'b1;
	req_we_i = we;
	req_addr_i = addr;
	req_wdata_i = wdata;
	accepted = 1'b0;
	while (!accepted) begin
		accepted = req_ready_o;
		@(posedge clk);
		#2;
	end
	req_valid_i = 1'b0;
	while (!rsp_valid_o) begin
		@(posedge clk);
		#2;
	end
	rdata = rsp_data_o;
endtask

task automatic snoop_access(input bus_msg_t msg, input logic [63:0] addr,
	output logic dirty, output logic [63:0] data);
	logic accepted;
	snoop_valid_i = 1'b1;
	snoop_msg_i = msg;
	snoop_addr_i = addr;
	accepted = 1'b0;
	while (!accepted) begin
		accepted = snoop_ready_o;
		@(posedge clk);
		#2;
	end
	snoop_valid_i = 1'b0;
	snoop_msg_i = MSG_NONE;
	@(posedge clk);
	#2;
	check_cond("snoop response did not come one cycle after acceptance", snoop_rsp_valid_o);
	dirty = snoop_rsp_dirty_o;
	data = snoop_rsp_data_o;
	// the dirty word reaches memory through the remote requester
	if (dirty) begin
		mem[line_addr(addr)] = data;
	end
endtask

// ****************************************
// directed tests
// ****************************************

task automatic test_reset_values();
	check_cond("req_ready_o low after reset", req_ready_o);
	check_cond("snoop_ready_o low after reset", snoop_ready_o);
	check_cond("a valid output is high after reset",
		!rsp_valid_o && !bus_req_valid_o && !snoop_rsp_valid_o);
endtask

task automatic test_load_miss_hit();
	logic [63:0] a;
	logic [63:0] exp;
	logic [63:0] got;
	int n0;
	a = 64'h100c;
	exp = mem_word(line_addr(a));
	n0 = log_msg.size();
	core_access(1'b0, a, '0, got);
	check_traffic(n0, 1, "load miss");
	check_bus(n0, MSG_GETS, line_addr(a));
	check_word("load miss data", got, exp);
	n0 = log_msg.size();
	core_access(1'b0, a, '0, got);
	check_traffic(n0, 0, "load hit");
	check_word("load hit data", got, exp);
endtask

task automatic test_store_miss();
	logic [63:0] got;
	int n0;
	n0 = log_msg.size();
	core_access(1'b1, STORE_ADDR, STORE_WORD, got);
	check_traffic(n0, 1, "store miss");
	check_bus(n0, MSG_GETM, STORE_ADDR);
	check_word("store response data", got, '0);
	n0 = log_msg.size();
	core_access(1'b0, STORE_ADDR, '0, got);
	check_traffic(n0, 0, "load after store");
	check_word("load after store", got, STORE_WORD);
endtask

task automatic test_eviction();
	logic [63:0] a;
	logic [63:0] exp;
	logic [63:0] got;
	int n0;
	// same index as STORE_ADDR with another tag
	a = 64'h3010;
	exp = mem_word(a);
	n0 = log_msg.size();
	core_access(1'b0, a, '0, got);
	check_traffic(n0, 2, "eviction");
	check_bus(n0, MSG_PUTM, STORE_ADDR);
	if (log_data.size() > n0) begin
		check_word("victim write-back data", log_data[n0], STORE_WORD);
	end
	check_bus(n0 + 1, MSG_GETS, a);
	check_word("load after eviction", got, exp);
	check_word("memory after write-back", mem[STORE_ADDR], STORE_WORD);
endtask

task automatic test_snoop_gets();
	logic [63:0] w1;
	logic [63:0] w2;
	logic [63:0] got;
	logic dirty;
	int n0;
	w1 = 64'h0bad_cafe_1111_2222;
	w2 = 64'h7777_8888_9999_aaaa;
	core_access(1'b1, SNOOP_ADDR, w1, got);
	snoop_access(MSG_GETS, SNOOP_ADDR, dirty, got);
	check_cond("remote GetS on an M line gave a clean response", dirty);
	check_word("remote GetS data", got, w1);
	n0 = log_msg.size();
	core_access(1'b1, SNOOP_ADDR, w2, got);
	check_traffic(n0, 1, "upgrade store");
	check_bus(n0, MSG_GETM, SNOOP_ADDR);
	n0 = log_msg.size();
	core_access(1'b0, SNOOP_ADDR, '0, got);
	check_traffic(n0, 0, "load after upgrade");
	check_word("load after upgrade", got, w2);
endtask

task automatic test_snoop_getm();
	logic [63:0] got;
	logic [63:0] word;
	logic dirty;
	int n0;
	snoop_access(MSG_GETM, SNOOP_ADDR, dirty, word);
	check_cond("remote GetM on an M line gave a clean response", dirty);
	check_word("remote GetM data", word, 64'h7777_8888_9999_aaaa);
	n0 = log_msg.size();
	core_access(1'b0, SNOOP_ADDR, '0, got);
	check_traffic(n0, 1, "load after invalidation");
	check_bus(n0, MSG_GETS, SNOOP_ADDR);
	check_word("load after invalidation", got, 64'h7777_8888_9999_aaaa);
endtask

task automatic test_backpressure();
	logic [63:0] a;
	logic [63:0] exp;
	logic [63:0] got;
	logic [63:0] held_addr;
	bus_msg_t held_msg;
	int hold;
	int n0;
	a = 64'h6028;
	hold = {$random(seed)} % 8 + 1;
	exp = mem_word(a);
	n0 = log_msg.size();
	bus_req_ready_i = 1'b0;
	fork
		core_access(1'b0, a, '0, got);
		begin
			while (!bus_req_valid_o) begin
				@(posedge clk);
				#2;
			end
			held_msg = bus_req_msg_o;
			held_addr = bus_req_addr_o;
			repeat (hold) begin
				@(posedge clk);
				#2;
				check_cond("bus request dropped while stalled", bus_req_valid_o);
				check_word("stalled request message", bus_req_msg_o, held_msg);
				check_word("stalled request address", bus_req_addr_o, held_addr);
			end
			bus_req_ready_i = 1'b1;
		end
	join
	check_traffic(n0, 1, "stalled load");
	check_bus(n0, MSG_GETS, a);
	check_word("stalled load data", got, exp);
endtask

`endif

// ==== test/tb_dcache.sv ====
`timescale 1ns/10ps

`include "dcache_settings.svh"

module tb_dcache;

	import bus_pkg::*;

	// longest test is well under 100 cycles
	localparam int CYCLE_LIMIT = 2000;

	logic							clk;
	logic							arst_n_i;
	logic							req_valid_i;
	logic							req_ready_o;
	logic							req_we_i;
	logic	[`DCACHE_ADDR_W-1:0]	req_addr_i;
	logic	[`DCACHE_WORD_W-1:0]	req_wdata_i;
	logic							rsp_valid_o;
	logic	[`DCACHE_WORD_W-1:0]	rsp_data_o;
	logic							bus_req_valid_o;
	logic							bus_req_ready_i;
	bus_msg_t						bus_req_msg_o;
	logic	[`DCACHE_ADDR_W-1:0]	bus_req_addr_o;
	logic	[`DCACHE_WORD_W-1:0]	bus_req_data_o;
	logic							bus_fill_valid_i;
	logic	[`DCACHE_WORD_W-1:0]	bus_fill_data_i;
	logic							snoop_valid_i;
	logic							snoop_ready_o;
	bus_msg_t						snoop_msg_i;
	logic	[`DCACHE_ADDR_W-1:0]	snoop_addr_i;
	logic							snoop_rsp_valid_o;
	logic							snoop_rsp_dirty_o;
	logic	[`DCACHE_WORD_W-1:0]	snoop_rsp_data_o;

	integer		seed = 53652;
	int			errors = 0;
	int			checks = 0;
	int			tests = 0;
	int			cycles = 0;
	int			err_start;

	// ****************************************
	// bus memory model
	// ****************************************

	logic	[63:0]	mem [logic [63:0]];
	bus_msg_t		log_msg [$];
	logic	[63:0]	log_addr [$];
	logic	[63:0]	log_data [$];
	logic	[63:0]	fill_addr;
	int				fill_wait = 0;
	logic			fill_now;

	// words appear on first touch and are mixed with their address
	function automatic logic [63:0] mem_word(input logic [63:0] a);
		if (!mem.exists(a)) begin
			mem[a] = {$random(seed), $random(seed)} ^ a;
		end
		return mem[a];
	endfunction

	always @(posedge clk) begin
		fill_now = 1'b0;
		if (fill_wait > 0) begin
			fill_wait--;
			fill_now = (fill_wait == 0);
		end
		if (bus_req_valid_o && bus_req_ready_i) begin
			log_msg.push_back(bus_req_msg_o);
			log_addr.push_back(bus_req_addr_o);
			log_data.push_back(bus_req_data_o);
			if (bus_req_msg_o == MSG_PUTM) begin
				mem[bus_req_addr_o] = bus_req_data_o;
			end else begin
				fill_addr = bus_req_addr_o;
				fill_wait = 3;
			end
		end
		#2;
		bus_fill_valid_i = fill_now;
		bus_fill_data_i = fill_now ? mem_word(fill_addr) : '0;
	end

	dcache dcache_inst (.*);

	`include "tb_dcache_tasks.svh"

	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		arst_n_i = 1'b0;
		req_valid_i = 1'b0;
		req_we_i = 1'b0;
		req_addr_i = '0;
		req_wdata_i = '0;
		bus_req_ready_i = 1'b1;
		bus_fill_valid_i = 1'b0;
		bus_fill_data_i = '0;
		snoop_valid_i = 1'b0;
		snoop_msg_i = MSG_NONE;
		snoop_addr_i = '0;
		repeat (5) @(posedge clk);
		#2;
		arst_n_i = 1'b1;

		err_start = errors;
		test_reset_values();
		report_test("reset values", err_start);
		err_start = errors;
		test_load_miss_hit();
		report_test("load miss then hit", err_start);
		err_start = errors;
		test_store_miss();
		report_test("store miss", err_start);
		err_start = errors;
		test_eviction();
		report_test("eviction", err_start);
		err_start = errors;
		test_snoop_gets();
		report_test("remote GetS on M line", err_start);
		err_start = errors;
		test_snoop_getm();
		report_test("remote GetM", err_start);
		err_start = errors;
		test_backpressure();
		report_test("back-pressure", err_start);

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule: tb_dcache

// ==== src/dcache.sv ====
`timescale 1ns/10ps

`include "dcache_settings.svh"

module dcache (
	input									clk,
	input									arst_n_i,

	// core side
	input									req_valid_i,
	output	logic							req_ready_o,
	input									req_we_i,
	input			[`DCACHE_ADDR_W-1:0]	req_addr_i,
	input			[`DCACHE_WORD_W-1:0]	req_wdata_i,
	output	logic							rsp_valid_o,
	output	logic	[`DCACHE_WORD_W-1:0]	rsp_data_o,

	// bus side
	output	logic							bus_req_valid_o,
	input									bus_req_ready_i,
	output	bus_pkg::bus_msg_t				bus_req_msg_o,
	output	logic	[`DCACHE_ADDR_W-1:0]	bus_req_addr_o,
	output	logic	[`DCACHE_WORD_W-1:0]	bus_req_data_o,
	input									bus_fill_valid_i,
	input			[`DCACHE_WORD_W-1:0]	bus_fill_data_i,

	// snoops
	input									snoop_valid_i,
	output	logic							snoop_ready_o,
	input	bus_pkg::bus_msg_t				snoop_msg_i,
	input			[`DCACHE_ADDR_W-1:0]	snoop_addr_i,
	output	logic							snoop_rsp_valid_o,
	output	logic							snoop_rsp_dirty_o,
	output	logic	[`DCACHE_WORD_W-1:0]	snoop_rsp_data_o
);

	import cache_pkg::*;

	// lookup between controller and arrays
	logic	[`DCACHE_IDX_W-1:0]			lk_idx;
	logic	[`DCACHE_TAG_W-1:0]			lk_tag;
	logic								lk_hit;
	line_state_t						lk_state;
	logic	[`DCACHE_TAG_W-1:0]			lk_stored_tag;
	logic	[`DCACHE_WORD_W-1:0]		lk_data;

	// line and state writes
	logic								wr_en;
	logic	[`DCACHE_IDX_W-1:0]			wr_idx;
	logic	[`DCACHE_TAG_W-1:0]			wr_tag;
	logic	[`DCACHE_WORD_W-1:0]		wr_data;
	line_state_t						wr_state;
	logic								st_en;
	logic	[`DCACHE_IDX_W-1:0]			st_idx;
	line_state_t						st_state;

	dcache_ctrl dcache_ctrl_inst (
		.clk				(clk),
		.arst_n_i			(arst_n_i),
		.req_valid_i		(req_valid_i),
		.req_ready_o		(req_ready_o),
		.req_we_i			(req_we_i),
		.req_addr_i			(req_addr_i),
		.req_wdata_i		(req_wdata_i),
		.rsp_valid_o		(rsp_valid_o),
		.rsp_data_o			(rsp_data_o),
		.bus_req_valid_o	(bus_req_valid_o),
		.bus_req_ready_i	(bus_req_ready_i),
		.bus_req_msg_o		(bus_req_msg_o),
		.bus_req_addr_o		(bus_req_addr_o),
		.bus_req_data_o		(bus_req_data_o),
		.bus_fill_valid_i	(bus_fill_valid_i),
		.bus_fill_data_i	(bus_fill_data_i),
		.snoop_valid_i		(snoop_valid_i),
		.snoop_ready_o		(snoop_ready_o),
		.snoop_msg_i		(snoop_msg_i),
		.snoop_addr_i		(snoop_addr_i),
		.snoop_rsp_valid_o	(snoop_rsp_valid_o),
		.snoop_rsp_dirty_o	(snoop_rsp_dirty_o),
		.snoop_rsp_data_o	(snoop_rsp_data_o),
		.lk_idx_o			(lk_idx),
		.lk_tag_o			(lk_tag),
		.lk_hit_i			(lk_hit),
		.lk_state_i			(lk_state),
		.lk_tag_i			(lk_stored_tag),
		.lk_data_i			(lk_data),
		.wr_en_o			(wr_en),
		.wr_idx_o			(wr_idx),
		.wr_tag_o			(wr_tag),
		.wr_data_o			(wr_data),
		.wr_state_o			(wr_state),
		.st_en_o			(st_en),
		.st_idx_o			(st_idx),
		.st_state_o			(st_state)
	);

	dcache_mem dcache_mem_inst (
		.clk				(clk),
		.arst_n_i			(arst_n_i),
		.lk_idx_i			(lk_idx),
		.lk_tag_i			(lk_tag),
		.lk_hit_o			(lk_hit),
		.lk_state_o			(lk_state),
		.lk_tag_o			(lk_stored_tag),
		.lk_data_o			(lk_data),
		.wr_en_i			(wr_en),
		.wr_idx_i			(wr_idx),
		.wr_tag_i			(wr_tag),
		.wr_data_i			(wr_data),
		.wr_state_i			(wr_state),
		.st_en_i			(st_en),
		.st_idx_i			(st_idx),
		.st_state_i			(st_state)
	);

endmodule: dcache

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/10ps

`include "dcache_settings.svh"

module dcache_ctrl (
	input									clk,
	input									arst_n_i,

	// core side
	input									req_valid_i,
	output	logic							req_ready_o,
	input									req_we_i,
	input			[`DCACHE_ADDR_W-1:0]	req_addr_i,
	input			[`DCACHE_WORD_W-1:0]	req_wdata_i,
	output	logic							rsp_valid_o,
	output	logic	[`DCACHE_WORD_W-1:0]	rsp_data_o,

	// bus requests and fills
	output	logic							bus_req_valid_o,
	input									bus_req_ready_i,
	output	bus_pkg::bus_msg_t				bus_req_msg_o,
	output	logic	[`DCACHE_ADDR_W-1:0]	bus_req_addr_o,
	output	logic	[`DCACHE_WORD_W-1:0]	bus_req_data_o,
	input									bus_fill_valid_i,
	input			[`DCACHE_WORD_W-1:0]	bus_fill_data_i,

	// snoops from other caches
	input									snoop_valid_i,
	output	logic							snoop_ready_o,
	input	bus_pkg::bus_msg_t				snoop_msg_i,
	input			[`DCACHE_ADDR_W-1:0]	snoop_addr_i,
	output	logic							snoop_rsp_valid_o,
	output	logic							snoop_rsp_dirty_o,
	output	logic	[`DCACHE_WORD_W-1:0]	snoop_rsp_data_o,

	// memory lookup
	output	logic	[`DCACHE_IDX_W-1:0]		lk_idx_o,
	output	logic	[`DCACHE_TAG_W-1:0]		lk_tag_o,
	input									lk_hit_i,
	input	cache_pkg::line_state_t			lk_state_i,
	input			[`DCACHE_TAG_W-1:0]		lk_tag_i,
	input			[`DCACHE_WORD_W-1:0]	lk_data_i,

	// memory writes
	output	logic							wr_en_o,
	output	logic	[`DCACHE_IDX_W-1:0]		wr_idx_o,
	output	logic	[`DCACHE_TAG_W-1:0]		wr_tag_o,
	output	logic	[`DCACHE_WORD_W-1:0]	wr_data_o,
	output	cache_pkg::line_state_t			wr_state_o,
	output	logic							st_en_o,
	output	logic	[`DCACHE_IDX_W-1:0]		st_idx_o,
	output	cache_pkg::line_state_t			st_state_o
);

	import cache_pkg::*;
	import bus_pkg::*;

	ctrl_state_t						state_q;
	ctrl_state_t						state_d;

	// accepted core request
	logic								req_we_q;
	logic	[`DCACHE_TAG_W-1:0]			req_tag_q;
	logic	[`DCACHE_IDX_W-1:0]			req_idx_q;
	logic	[`DCACHE_WORD_W-1:0]		req_wdata_q;

	// accepted snoop
	bus_msg_t							snoop_msg_q;
	logic	[`DCACHE_TAG_W-1:0]			snoop_tag_q;
	logic	[`DCACHE_IDX_W-1:0]			snoop_idx_q;

	logic								req_acc;
	logic								snoop_acc;
	logic								load_done;
	logic								store_done;
	logic								victim_dirty;
	logic								snoop_dirty;

	// ****************************************
	// handshakes and lookup
	// ****************************************

	// snoops win over a new core request
	assign snoop_ready_o	= (state_q == C_IDLE);
	assign req_ready_o		= (state_q == C_IDLE) && !snoop_valid_i;
	assign snoop_acc		= snoop_valid_i && snoop_ready_o;
	assign req_acc			= req_valid_i && req_ready_o;

	assign lk_idx_o	= (state_q == C_SNOOP_RSP) ? snoop_idx_q : req_idx_q;
	assign lk_tag_o	= (state_q == C_SNOOP_RSP) ? snoop_tag_q : req_tag_q;

	assign load_done	= lk_hit_i && !req_we_q;
	assign store_done	= lk_hit_i && req_we_q && (lk_state_i == ST_M);
	// another tag sits modified in the set
	assign victim_dirty	= !lk_hit_i && (lk_state_i == ST_M);
	assign snoop_dirty	= lk_hit_i && (lk_state_i == ST_M);

	// ****************************************
	// FSM
	// ****************************************

	always_comb begin
		state_d			= state_q;
		bus_req_valid_o	= 1'b0;
		bus_req_msg_o	= MSG_NONE;
		bus_req_addr_o	= '0;
		bus_req_data_o	= '0;
		wr_en_o			= 1'b0;
		wr_idx_o		= req_idx_q;
		wr_tag_o		= req_tag_q;
		wr_data_o		= req_wdata_q;
		wr_state_o		= ST_M;
		st_en_o			= 1'b0;
		st_idx_o		= lk_idx_o;
		st_state_o		= ST_I;

		case (state_q)
			C_IDLE: begin
				if (snoop_acc) begin
					state_d = C_SNOOP_RSP;
				end else if (req_acc) begin
					state_d = C_RSP;
				end
			end

			// answers the held request on a usable hit
			C_RSP: begin
				if (load_done) begin
					state_d = C_IDLE;
				end else if (store_done) begin
					wr_en_o = 1'b1;
					state_d = C_IDLE;
				end else if (victim_dirty) begin
					state_d = C_WB;
				end else begin
					// plain miss or upgrade of an S line
					state_d = C_MISS_REQ;
				end
			end

			C_WB: begin
				bus_req_valid_o	= 1'b1;
				bus_req_msg_o	= MSG_PUTM;
				bus_req_addr_o	= {lk_tag_i, req_idx_q, {`DCACHE_OFS_W{1'b0}}};
				bus_req_data_o	= lk_data_i;
				if (bus_req_ready_i) begin
					// memory owns the victim now
					st_en_o = 1'b1;
					state_d = C_MISS_REQ;
				end
			end

			C_MISS_REQ: begin
				bus_req_valid_o	= 1'b1;
				bus_req_addr_o	= {req_tag_q, req_idx_q, {`DCACHE_OFS_W{1'b0}}};
				if (req_we_q) begin
					bus_req_msg_o = MSG_GETM;
				end else begin
					bus_req_msg_o = MSG_GETS;
				end
				if (bus_req_ready_i) begin
					state_d = C_FILL;
				end
			end

			C_FILL: begin
				if (bus_fill_valid_i) begin
					wr_en_o = 1'b1;
					// full word store replaces the filled word
					if (req_we_q) begin
						wr_data_o	= req_wdata_q;
						wr_state_o	= ST_M;
					end else begin
						wr_data_o	= bus_fill_data_i;
						wr_state_o	= ST_S;
					end
					state_d = C_RSP;
				end
			end

			C_SNOOP_RSP: begin
				if (lk_hit_i && (snoop_msg_q == MSG_GETM)) begin
					st_en_o		= 1'b1;
					st_state_o	= ST_I;
				end else if (snoop_dirty && (snoop_msg_q == MSG_GETS)) begin
					st_en_o		= 1'b1;
					st_state_o	= ST_S;
				end
				state_d = C_IDLE;
			end

			default: begin
				state_d = C_IDLE;
			end
		endcase
	end

	// ****************************************
	// registers
	// ****************************************

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q				<= C_IDLE;
			rsp_valid_o			<= 1'b0;
			snoop_rsp_valid_o	<= 1'b0;
		end else begin
			state_q				<= state_d;
			rsp_valid_o			<= (state_q == C_RSP) && (load_done || store_done);
			snoop_rsp_valid_o	<= (state_q == C_SNOOP_RSP);
		end
	end

	always_ff @(posedge clk) begin
		if (req_acc) begin
			req_we_q	<= req_we_i;
			req_tag_q	<= req_addr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
			req_idx_q	<= req_addr_i[`DCACHE_OFS_W +: `DCACHE_IDX_W];
			req_wdata_q	<= req_wdata_i;
		end
		if (snoop_acc) begin
			snoop_msg_q	<= snoop_msg_i;
			snoop_tag_q	<= snoop_addr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
			snoop_idx_q	<= snoop_addr_i[`DCACHE_OFS_W +: `DCACHE_IDX_W];
		end
		// stores answer with zero
		if (state_q == C_RSP) begin
			rsp_data_o <= req_we_q ? '0 : lk_data_i;
		end
		if (state_q == C_SNOOP_RSP) begin
			snoop_rsp_dirty_o	<= snoop_dirty;
			snoop_rsp_data_o	<= snoop_dirty ? lk_data_i : '0;
		end
	end

	// ****************************************
	// checks
	// ****************************************

	// a stalled bus request holds every field until taken
	assert property (@(posedge clk) disable iff (!arst_n_i)
		bus_req_valid_o && !bus_req_ready_i |=> bus_req_valid_o
			&& $stable(bus_req_msg_o) && $stable(bus_req_addr_o)
			&& $stable(bus_req_data_o));

	// one pulse per request
	assert property (@(posedge clk) disable iff (!arst_n_i)
		rsp_valid_o |=> !rsp_valid_o);

endmodule: dcache_ctrl

// ==== src/dcache_mem.sv ====
`timescale 1ns/10ps

`include "dcache_settings.svh"

module dcache_mem (
	input									clk,
	input									arst_n_i,

	// lookup
	input			[`DCACHE_IDX_W-1:0]		lk_idx_i,
	input			[`DCACHE_TAG_W-1:0]		lk_tag_i,
	output	logic							lk_hit_o,
	output	cache_pkg::line_state_t			lk_state_o,
	output	logic	[`DCACHE_TAG_W-1:0]		lk_tag_o,
	output	logic	[`DCACHE_WORD_W-1:0]	lk_data_o,

	// full line write
	input									wr_en_i,
	input			[`DCACHE_IDX_W-1:0]		wr_idx_i,
	input			[`DCACHE_TAG_W-1:0]		wr_tag_i,
	input			[`DCACHE_WORD_W-1:0]	wr_data_i,
	input	cache_pkg::line_state_t			wr_state_i,

	// state-only write
	input									st_en_i,
	input			[`DCACHE_IDX_W-1:0]		st_idx_i,
	input	cache_pkg::line_state_t			st_state_i
);

	import cache_pkg::*;

	// ****************************************
	// arrays
	// ****************************************

	// one entry per set
	line_state_t						state_q [`DCACHE_SETS];
	logic	[`DCACHE_TAG_W-1:0]			tag_q [`DCACHE_SETS];
	logic	[`DCACHE_WORD_W-1:0]		data_q [`DCACHE_SETS];

	// ****************************************
	// lookup
	// ****************************************

	assign lk_state_o	= state_q[lk_idx_i];
	assign lk_tag_o		= tag_q[lk_idx_i];
	assign lk_data_o	= data_q[lk_idx_i];

	// stored tag doubles as the victim tag on a miss
	assign lk_hit_o		= (lk_state_o != ST_I) && (lk_tag_o == lk_tag_i);

	// ****************************************
	// writes
	// ****************************************

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `DCACHE_SETS; i++) begin
				state_q[i] <= ST_I;
			end
		end else begin
			// fill or store hit
			if (wr_en_i) begin
				state_q[wr_idx_i] <= wr_state_i;
			end
			// snoop downgrade / invalidate, victim drop
			if (st_en_i) begin
				state_q[st_idx_i] <= st_state_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_q[wr_idx_i]		<= wr_tag_i;
			data_q[wr_idx_i]	<= wr_data_i;
		end
	end

	// ****************************************
	// checks on the controller
	// ****************************************

	// fill and snoop paths are serialized by the controller FSM
	assert property (@(posedge clk) disable iff (!arst_n_i)
		!(wr_en_i && st_en_i && (wr_idx_i == st_idx_i)));

	// a line write always leaves a valid copy
	assert property (@(posedge clk) disable iff (!arst_n_i)
		wr_en_i |-> (wr_state_i != ST_I));

endmodule: dcache_mem

// ==== src/cache_pkg.sv ====
package cache_pkg;

	// per line coherence state
	typedef enum logic [1:0] {
		ST_I,
		ST_S,
		ST_M
	} line_state_t;

	// controller FSM
	typedef enum logic [2:0] {
		C_IDLE,
		C_WB,
		C_MISS_REQ,
		C_FILL,
		C_RSP,
		C_SNOOP_RSP
	} ctrl_state_t;

endpackage: cache_pkg

// ==== src/bus_pkg.sv ====
package bus_pkg;

	// ****************************************
	// snooping bus messages
	// ****************************************

	// none marks an idle request slot
	typedef enum logic [1:0] {
		MSG_NONE,
		MSG_GETS,
		MSG_GETM,
		MSG_PUTM
	} bus_msg_t;

	// GetS asks for a shared copy, GetM for ownership,
	// PutM hands a modified line back to memory

endpackage: bus_pkg

// ==== src/dcache_settings.svh ====
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ****************************************
// address split
// ****************************************
`define DCACHE_ADDR_W	64
`define DCACHE_OFS_W	3
`define DCACHE_IDX_W	4

// whatever is left above index and offset
`define DCACHE_TAG_W	(`DCACHE_ADDR_W - `DCACHE_IDX_W - `DCACHE_OFS_W)

// ****************************************
// geometry
// ****************************************
`define DCACHE_SETS		(1 << `DCACHE_IDX_W)
`define DCACHE_WORD_W	64

`endif
